//--- design/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// major opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// function field, only meaningful under OP_SPECIAL
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} aluOp_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE
	} branch_e;

	// register format fields
	typedef struct packed {
		opcode_e    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} rView_t;

	// immediate format fields, jump target is {rs, rt, imm}
	typedef struct packed {
		opcode_e     op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iView_t;

	typedef union packed {
		rView_t rView;
		iView_t iView;
	} instrWord_u;

	// all-zero value is a bubble
	typedef struct packed {
		logic   regWrite;
		logic   memToReg;
		logic   memWrite;
		logic   aluSrcImm;
		logic   regDstRd;
		logic   zeroExtend;
		aluOp_e aluOp;
	} ctrl_t;

endpackage

`default_nettype wire

//--- design/hazardIf.sv
`default_nettype none

interface hazardIf;

	// decode stage sources
	logic [4:0] rsD;
	logic [4:0] rtD;
	logic       branchD;
	// execute stage
	logic [4:0] rsE;
	logic [4:0] rtE;
	logic [4:0] writeRegE;
	logic       regWriteE;
	logic       memToRegE;
	// memory stage
	logic [4:0] writeRegM;
	logic       regWriteM;
	logic       memToRegM;
	// writeback stage
	logic [4:0] writeRegW;
	logic       regWriteW;
	// answers from the hazard unit
	logic       forwardAD;
	logic       forwardBD;
	logic [1:0] forwardAE;
	logic [1:0] forwardBE;
	logic       stallF;
	logic       stallD;
	logic       flushE;

	modport dp (
		output rsD, rtD, branchD, rsE, rtE,
		output writeRegE, regWriteE, memToRegE,
		output writeRegM, regWriteM, memToRegM,
		output writeRegW, regWriteW,
		input  forwardAD, forwardBD, forwardAE, forwardBE,
		input  stallF, stallD, flushE
	);

	modport hz (
		input  rsD, rtD, branchD, rsE, rtE,
		input  writeRegE, regWriteE, memToRegE,
		input  writeRegM, regWriteM, memToRegM,
		input  writeRegW, regWriteW,
		output forwardAD, forwardBD, forwardAE, forwardBE,
		output stallF, stallD, flushE
	);

endinterface

`default_nettype wire

//--- design/controlDecoder.sv
`default_nettype none

module controlDecoder import mipsPkg::*; (
	input  instrWord_u instr,
	output ctrl_t      ctrl,
	output branch_e    branch,
	output logic       jump
);

	always_comb begin
		// default is a bubble
		ctrl = '0;
		branch = BR_NONE;
		jump = 1'b0;
		case (instr.rView.op)
			OP_SPECIAL: begin
				// register ops write rd
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (instr.rView.funct)
					FN_ADDU: ctrl.aluOp = ALU_ADD;
					FN_SUBU: ctrl.aluOp = ALU_SUB;
					FN_AND:  ctrl.aluOp = ALU_AND;
					FN_OR:   ctrl.aluOp = ALU_OR;
					FN_SLT:  ctrl.aluOp = ALU_SLT;
					// nop and unsupported functions
					default: ctrl = '0;
				endcase
			end
			OP_ADDIU: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			OP_LUI: begin
				// upper half comes from the raw immediate
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExtend = 1'b1;
				ctrl.aluOp = ALU_LUI;
			end
			OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			OP_SW: begin
				// address is base plus offset
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			OP_BEQ: branch = BR_EQ;
			OP_BNE: branch = BR_NE;
			OP_J:   jump = 1'b1;
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/registerFile.sv
`default_nettype none

module registerFile (
	input  logic        clk,
	input  logic        writeEnable,
	input  logic [4:0]  readNumA,
	input  logic [4:0]  readNumB,
	input  logic [4:0]  writeNum,
	input  logic [31:0] writeData,
	output logic [31:0] readDataA,
	output logic [31:0] readDataB
);

	logic [31:0] regs [32];

	// register 0 is never stored
	always_ff @(posedge clk) begin
		if (writeEnable && writeNum != 5'd0) begin
			regs[writeNum] <= writeData;
		end
	end

	// reads see a write of the same cycle
	always_comb begin
		if (readNumA == 5'd0) readDataA = 32'd0;
		else if (writeEnable && writeNum == readNumA) readDataA = writeData;
		else readDataA = regs[readNumA];
		if (readNumB == 5'd0) readDataB = 32'd0;
		else if (writeEnable && writeNum == readNumB) readDataB = writeData;
		else readDataB = regs[readNumB];
	end

endmodule

`default_nettype wire

//--- design/arithUnit.sv
`default_nettype none

module arithUnit import mipsPkg::*; (
	input  logic [31:0] operandA,
	input  logic [31:0] operandB,
	input  aluOp_e      op,
	output logic [31:0] result
);

	always_comb begin
		case (op)
			ALU_ADD: result = operandA + operandB;
			ALU_SUB: result = operandA - operandB;
			ALU_AND: result = operandA & operandB;
			ALU_OR:  result = operandA | operandB;
			// signed compare
			ALU_SLT: begin
				result = {31'd0, $signed(operandA) < $signed(operandB)};
			end
			// immediate into the upper half
			ALU_LUI: result = {operandB[15:0], 16'd0};
			default: result = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/hazardUnit.sv
`default_nettype none

module hazardUnit (
	hazardIf.hz hz
);

	logic loadUseStall;
	logic branchStall;

	// execute forwarding, 10 from memory, 01 from writeback
	always_comb begin
		if (hz.regWriteM && hz.writeRegM != 5'd0 && hz.writeRegM == hz.rsE) begin
			hz.forwardAE = 2'b10;
		end else if (hz.regWriteW && hz.writeRegW != 5'd0 && hz.writeRegW == hz.rsE) begin
			hz.forwardAE = 2'b01;
		end else begin
			hz.forwardAE = 2'b00;
		end
		if (hz.regWriteM && hz.writeRegM != 5'd0 && hz.writeRegM == hz.rtE) begin
			hz.forwardBE = 2'b10;
		end else if (hz.regWriteW && hz.writeRegW != 5'd0 && hz.writeRegW == hz.rtE) begin
			hz.forwardBE = 2'b01;
		end else begin
			hz.forwardBE = 2'b00;
		end
	end

	// decode compare takes the alu result in memory
	// writeback is covered by the register file bypass
	assign hz.forwardAD = hz.regWriteM && hz.writeRegM != 5'd0 && hz.writeRegM == hz.rsD;
	assign hz.forwardBD = hz.regWriteM && hz.writeRegM != 5'd0 && hz.writeRegM == hz.rtD;

	// load in execute feeding decode
	assign loadUseStall = hz.memToRegE && hz.writeRegE != 5'd0
		&& (hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD);

	// branch operand not ready yet
	// either computed in execute or loaded in memory
	assign branchStall = hz.branchD
		&& ((hz.regWriteE && hz.writeRegE != 5'd0
			&& (hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD))
		|| (hz.memToRegM && hz.writeRegM != 5'd0
			&& (hz.writeRegM == hz.rsD || hz.writeRegM == hz.rtD)));

	// hold fetch and decode, bubble into execute
	assign hz.stallF = loadUseStall || branchStall;
	assign hz.stallD = loadUseStall || branchStall;
	assign hz.flushE = loadUseStall || branchStall;

endmodule

`default_nettype wire

//--- design/pipelineDatapath.sv
`default_nettype none

module pipelineDatapath import mipsPkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst,
	hazardIf.dp         hz,
	output logic [31:0] instrAddr,
	input  logic [31:0] instrData,
	output logic [31:0] dataAddr,
	output logic        dataWrite,
	output logic [31:0] dataWriteData,
	input  logic [31:0] dataReadData,
	output logic [31:0] tracePc,
	output logic        traceRegWrite,
	output logic [4:0]  traceRegNum,
	output logic [31:0] traceRegData
);

	// fetch
	logic [31:0] pcF, pcNextF;
	// decode
	instrWord_u  instrD;
	logic [31:0] pcD, pcPlus4D, immD, regAD, regBD, srcAD, srcBD;
	logic [31:0] branchTargetD, jumpTargetD;
	ctrl_t       ctrlD;
	branch_e     branchTypeD;
	logic        jumpD, equalD, takenD, redirectD;
	// execute
	ctrl_t       ctrlE;
	logic [31:0] pcE, regAE, regBE, immE, srcAE, writeDataE, aluOutE;
	logic [4:0]  rsE, rtE, rdE, writeRegE;
	// memory
	ctrl_t       ctrlM;
	logic [31:0] pcM, aluOutM, writeDataM;
	logic [4:0]  writeRegM;
	// writeback
	ctrl_t       ctrlW;
	logic [31:0] pcW, aluOutW, readDataW, resultW;
	logic [4:0]  writeRegW;

	//////////////////////////////////////////////////////////////////////
	// fetch

	// redirect lands on the edge ending decode
	assign pcNextF = redirectD ? (jumpD ? jumpTargetD : branchTargetD) : pcF + 32'd4;

	always_ff @(posedge clk) begin
		if (rst) pcF <= RESET_PC;
		else if (!hz.stallF) pcF <= pcNextF;
	end

	assign instrAddr = pcF;

	//////////////////////////////////////////////////////////////////////
	// decode

	// zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (rst || redirectD) instrD <= '0;
		else if (!hz.stallD) instrD <= instrData;
	end

	always_ff @(posedge clk) begin
		if (!hz.stallD) pcD <= pcF;
	end

	controlDecoder decoder_i (
		.instr (instrD),
		.ctrl  (ctrlD),
		.branch(branchTypeD),
		.jump  (jumpD)
	);

	registerFile regFile_i (
		.clk        (clk),
		.writeEnable(ctrlW.regWrite),
		.readNumA   (instrD.rView.rs),
		.readNumB   (instrD.rView.rt),
		.writeNum   (writeRegW),
		.writeData  (resultW),
		.readDataA  (regAD),
		.readDataB  (regBD)
	);

	// lui wants the raw immediate
	assign immD = ctrlD.zeroExtend ? {16'd0, instrD.iView.imm}
		: {{16{instrD.iView.imm[15]}}, instrD.iView.imm};

	// branch compare operands
	assign srcAD = hz.forwardAD ? aluOutM : regAD;
	assign srcBD = hz.forwardBD ? aluOutM : regBD;
	assign equalD = srcAD == srcBD;

	assign pcPlus4D = pcD + 32'd4;
	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[31:28], instrD.iView.rs, instrD.iView.rt,
		instrD.iView.imm, 2'b00};

	assign takenD = (branchTypeD == BR_EQ && equalD) || (branchTypeD == BR_NE && !equalD);
	// no redirect while operands are stale
	assign redirectD = (takenD || jumpD) && !hz.stallD;

	assign hz.rsD = instrD.rView.rs;
	assign hz.rtD = instrD.rView.rt;
	assign hz.branchD = branchTypeD != BR_NONE;

	//////////////////////////////////////////////////////////////////////
	// execute

	always_ff @(posedge clk) begin
		if (rst || hz.flushE) ctrlE <= '0;
		else ctrlE <= ctrlD;
	end

	always_ff @(posedge clk) begin
		pcE <= pcD;
		regAE <= srcAD;
		regBE <= srcBD;
		immE <= immD;
		rsE <= instrD.rView.rs;
		rtE <= instrD.rView.rt;
		rdE <= instrD.rView.rd;
	end

	assign writeRegE = ctrlE.regDstRd ? rdE : rtE;

	// operand muxes, memory result wins over writeback
	always_comb begin
		case (hz.forwardAE)
			2'b10:   srcAE = aluOutM;
			2'b01:   srcAE = resultW;
			default: srcAE = regAE;
		endcase
		case (hz.forwardBE)
			2'b10:   writeDataE = aluOutM;
			2'b01:   writeDataE = resultW;
			default: writeDataE = regBE;
		endcase
	end

	arithUnit alu_i (
		.operandA(srcAE),
		.operandB(ctrlE.aluSrcImm ? immE : writeDataE),
		.op      (ctrlE.aluOp),
		.result  (aluOutE)
	);

	assign hz.rsE = rsE;
	assign hz.rtE = rtE;
	assign hz.writeRegE = writeRegE;
	assign hz.regWriteE = ctrlE.regWrite;
	assign hz.memToRegE = ctrlE.memToReg;

	//////////////////////////////////////////////////////////////////////
	// memory

	always_ff @(posedge clk) begin
		if (rst) ctrlM <= '0;
		else ctrlM <= ctrlE;
	end

	always_ff @(posedge clk) begin
		pcM <= pcE;
		aluOutM <= aluOutE;
		writeDataM <= writeDataE;
		writeRegM <= writeRegE;
	end

	assign dataAddr = aluOutM;
	assign dataWrite = ctrlM.memWrite;
	assign dataWriteData = writeDataM;

	assign hz.writeRegM = writeRegM;
	assign hz.regWriteM = ctrlM.regWrite;
	assign hz.memToRegM = ctrlM.memToReg;

	//////////////////////////////////////////////////////////////////////
	// writeback

	always_ff @(posedge clk) begin
		if (rst) ctrlW <= '0;
		else ctrlW <= ctrlM;
	end

	// load data is captured from the combinational read
	always_ff @(posedge clk) begin
		pcW <= pcM;
		aluOutW <= aluOutM;
		readDataW <= dataReadData;
		writeRegW <= writeRegM;
	end

	assign resultW = ctrlW.memToReg ? readDataW : aluOutW;

	assign hz.writeRegW = writeRegW;
	assign hz.regWriteW = ctrlW.regWrite;

	// trace, writes to register 0 do not count
	assign tracePc = pcW;
	assign traceRegWrite = ctrlW.regWrite && writeRegW != 5'd0;
	assign traceRegNum = writeRegW;
	assign traceRegData = resultW;

endmodule

`default_nettype wire

//--- design/mipsCore.sv
`default_nettype none

module mipsCore #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst,
	// instruction port
	output logic [31:0] instrAddr,
	input  logic [31:0] instrData,
	// data port
	output logic [31:0] dataAddr,
	output logic        dataWrite,
	output logic [31:0] dataWriteData,
	input  logic [31:0] dataReadData,
	// writeback trace
	output logic [31:0] tracePc,
	output logic        traceRegWrite,
	output logic [4:0]  traceRegNum,
	output logic [31:0] traceRegData
);

	// stage info out, stall and forward selects back
	hazardIf hazardBus ();

	pipelineDatapath #(
		.RESET_PC(RESET_PC)
	) datapath_i (
		.clk          (clk),
		.rst          (rst),
		.hz           (hazardBus.dp),
		.instrAddr    (instrAddr),
		.instrData    (instrData),
		.dataAddr     (dataAddr),
		.dataWrite    (dataWrite),
		.dataWriteData(dataWriteData),
		.dataReadData (dataReadData),
		.tracePc      (tracePc),
		.traceRegWrite(traceRegWrite),
		.traceRegNum  (traceRegNum),
		.traceRegData (traceRegData)
	);

	hazardUnit hazard_i (
		.hz(hazardBus.hz)
	);

endmodule

`default_nettype wire

//--- verification/isaModel.sv
`default_nettype none

module isaModel;

	// architectural state
	logic [31:0] imem [64];
	logic [31:0] dmem [256];
	logic [31:0] regs [32];

	// expected register writes in program order
	logic [31:0] wrPc [64];
	logic [4:0]  wrNum [64];
	logic [31:0] wrData [64];
	int          wrCount;
	// expected stores in program order
	logic [31:0] stAddr [64];
	logic [31:0] stData [64];
	int          stCount;
	// pc of the closing jump-to-self
	logic [31:0] endPc;

	task automatic loadInstr(input int idx, input logic [31:0] word);
		imem[idx] = word;
	endtask

	task automatic copyDataWord(input int idx, input logic [31:0] word);
		dmem[idx] = word;
	endtask

	// r0 writes are dropped and never listed
	task automatic recordWrite(input logic [31:0] pc, input logic [4:0] num,
		input logic [31:0] val);
		if (num != 5'd0) begin
			regs[num] = val;
			wrPc[wrCount] = pc;
			wrNum[wrCount] = num;
			wrData[wrCount] = val;
			wrCount++;
		end
	endtask

	task automatic runProgram(input logic [31:0] startPc);
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] instr;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sImm;
		logic [31:0] addr;
		logic [31:0] target;
		logic [5:0]  op;
		logic [5:0]  funct;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		int          steps;
		bit          done;
		for (int i = 0; i < 32; i++) regs[i] = 32'd0;
		wrCount = 0;
		stCount = 0;
		pc = startPc;
		done = 0;
		steps = 0;
		while (!done && steps < 1000) begin
			instr = imem[pc[7:2]];
			op = instr[31:26];
			rs = instr[25:21];
			rt = instr[20:16];
			rd = instr[15:11];
			funct = instr[5:0];
			sImm = {{16{instr[15]}}, instr[15:0]};
			a = regs[rs];
			b = regs[rt];
			nextPc = pc + 32'd4;
			case (op)
				6'h00: begin
					case (funct)
						6'h21: recordWrite(pc, rd, a + b);
						6'h23: recordWrite(pc, rd, a - b);
						6'h24: recordWrite(pc, rd, a & b);
						6'h25: recordWrite(pc, rd, a | b);
						6'h2a: recordWrite(pc, rd, {31'd0, $signed(a) < $signed(b)});
						default: ;
					endcase
				end
				6'h09: recordWrite(pc, rt, a + sImm);
				6'h0f: recordWrite(pc, rt, {instr[15:0], 16'd0});
				6'h23: begin
					addr = a + sImm;
					recordWrite(pc, rt, dmem[addr[9:2]]);
				end
				6'h2b: begin
					addr = a + sImm;
					dmem[addr[9:2]] = b;
					stAddr[stCount] = addr;
					stData[stCount] = b;
					stCount++;
				end
				6'h04: if (a == b) nextPc = pc + 32'd4 + {sImm[29:0], 2'b00};
				6'h05: if (a != b) nextPc = pc + 32'd4 + {sImm[29:0], 2'b00};
				6'h02: begin
					target = {nextPc[31:28], instr[25:0], 2'b00};
					// jump to itself closes the program
					if (target == pc) begin
						done = 1;
						endPc = pc;
					end
					nextPc = target;
				end
				default: ;
			endcase
			pc = nextPc;
			steps++;
		end
	endtask

endmodule

`default_nettype wire

//--- verification/coreTb.sv
`default_nettype none

module coreTb;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;
	localparam int PROG_LEN = 30;
	localparam int CYCLE_LIMIT = PROG_LEN * 3 + 50;
	localparam logic [31:0] SEED = 32'h30f52ecb;

	logic        clk;
	logic        rst;
	logic [31:0] instrAddr;
	logic [31:0] instrData;
	logic [31:0] dataAddr;
	logic        dataWrite;
	logic [31:0] dataWriteData;
	logic [31:0] dataReadData;
	logic [31:0] tracePc;
	logic        traceRegWrite;
	logic [4:0]  traceRegNum;
	logic [31:0] traceRegData;

	logic [31:0] imem [64];
	logic [31:0] dmem [256];

	int cycle;
	int wrIdx;
	int stIdx;
	int doneCycles;
	bit retired;
	// previous traced write
	int          lastRetireCycle;
	logic [31:0] lastRetirePc;
	int          expGap;

	mipsCore #(
		.RESET_PC(RESET_PC)
	) dut_i (
		.clk          (clk),
		.rst          (rst),
		.instrAddr    (instrAddr),
		.instrData    (instrData),
		.dataAddr     (dataAddr),
		.dataWrite    (dataWrite),
		.dataWriteData(dataWriteData),
		.dataReadData (dataReadData),
		.tracePc      (tracePc),
		.traceRegWrite(traceRegWrite),
		.traceRegNum  (traceRegNum),
		.traceRegData (traceRegData)
	);

	isaModel model_i ();

	// memories answer combinationally
	assign instrData = imem[instrAddr[7:2]];
	assign dataReadData = dmem[dataAddr[9:2]];

	always @(posedge clk) begin
		if (dataWrite) dmem[dataAddr[9:2]] <= dataWriteData;
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic reportMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		$display("** Error at time %0t: %s expected %h, got %h", $time, name, expVal, actVal);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic abortRun(input string what);
		$display("%s at time %0t", what, $time);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// cycles between two retires that sit next to each other in the program
	// one more when a load feeds the instruction right after it
	function automatic int retireSpacing(input logic [31:0] prevWord,
		input logic [31:0] curWord);
		bit feedsNext;
		feedsNext = prevWord[31:26] == 6'h23 && prevWord[20:16] != 5'd0
			&& (curWord[25:21] == prevWord[20:16]
			|| (curWord[31:26] == 6'h00 && curWord[20:16] == prevWord[20:16]));
		return feedsNext ? 2 : 1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// memory images and reset

	initial begin
		rst = 1'b1;
		cycle = 0;
		wrIdx = 0;
		stIdx = 0;
		doneCycles = 0;
		retired = 0;
		lastRetireCycle = 0;
		lastRetirePc = 32'd0;
		expGap = 0;
		void'($urandom(SEED));
		for (int i = 0; i < 64; i++) imem[i] = 32'd0;
		$readmemh("verification/program.hex", imem, 0, PROG_LEN - 1);
		// random data image
		// the model gets the same copy
		for (int i = 0; i < 256; i++) begin
			dmem[i] = $urandom;
			model_i.copyDataWord(i, dmem[i]);
		end
		for (int i = 0; i < 64; i++) model_i.loadInstr(i, imem[i]);
		model_i.runProgram(RESET_PC);
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// checks sampled mid-cycle

	always @(negedge clk) begin
		if (rst) begin
			assert (!dataWrite && !traceRegWrite)
			else abortRun("write strobe high during reset");
		end else begin
			// nothing is stored before the first retire
			if (!retired) begin
				assert (!dataWrite)
				else abortRun("store before the first retire");
			end
			if (traceRegWrite) begin
				if (!retired) begin
					// first retire lands four cycles after fetch starts
					assert (cycle == 4)
					else reportMismatch("first retire cycle", 4, cycle);
					assert (tracePc == RESET_PC)
					else reportMismatch("tracePc", RESET_PC, tracePc);
				end else if (tracePc == lastRetirePc + 32'd4) begin
					// neighbours in program order
					expGap = retireSpacing(imem[lastRetirePc[7:2]], imem[tracePc[7:2]]);
					assert (cycle - lastRetireCycle == expGap)
					else reportMismatch("retire spacing", expGap, cycle - lastRetireCycle);
				end
				retired = 1;
				lastRetireCycle = cycle;
				lastRetirePc = tracePc;
				assert (wrIdx < model_i.wrCount)
				else abortRun("register write beyond end of program");
				assert (tracePc == model_i.wrPc[wrIdx])
				else reportMismatch("tracePc", model_i.wrPc[wrIdx], tracePc);
				assert (traceRegNum == model_i.wrNum[wrIdx])
				else reportMismatch("traceRegNum", {27'd0, model_i.wrNum[wrIdx]},
					{27'd0, traceRegNum});
				assert (traceRegData == model_i.wrData[wrIdx])
				else reportMismatch("traceRegData", model_i.wrData[wrIdx], traceRegData);
				wrIdx++;
			end
			if (dataWrite) begin
				assert (stIdx < model_i.stCount)
				else abortRun("store beyond end of program");
				assert (dataAddr == model_i.stAddr[stIdx])
				else reportMismatch("dataAddr", model_i.stAddr[stIdx], dataAddr);
				assert (dataWriteData == model_i.stData[stIdx])
				else reportMismatch("dataWriteData", model_i.stData[stIdx], dataWriteData);
				stIdx++;
			end
			// closing loop reached
			// a few more cycles catch stray writes
			if (doneCycles > 0) begin
				doneCycles++;
			end else if (instrAddr == model_i.endPc && wrIdx == model_i.wrCount
				&& stIdx == model_i.stCount) begin
				doneCycles = 1;
			end
			cycle++;
			if (doneCycles > 6) begin
				$display("TEST OK");
				$finish;
			end else if (cycle > CYCLE_LIMIT) begin
				abortRun("timeout, program did not finish");
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/program.hex
// one 32-bit instruction word per line, word address 0 upward
// register ops, forwarding, load-use, stores, branches, jump, final loop
24010005
2402FFFD
00221821
00612023
00832824
00A23025
0041382A
3C081234
24000007
240A0040
AD480004
8D4B0004
01616021
8D4D0008
01A07025
AD4E000C
240F0001
11E70001
24100099
15E70001
24110022
8D52000C
124E0001
24130077
0800001A
24140055
022CA821
AD550010
0800001C
24160066

//--- src.f
design/mipsPkg.sv
design/hazardIf.sv
design/controlDecoder.sv
design/registerFile.sv
design/arithUnit.sv
design/hazardUnit.sv
design/pipelineDatapath.sv
design/mipsCore.sv
verification/isaModel.sv
verification/coreTb.sv

//--- Makefile
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/VcoreTb: src.f
	verilator --binary -f src.f --top-module coreTb -o VcoreTb

run: obj_dir/VcoreTb
	./obj_dir/VcoreTb | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	verilator --lint-only -Wall -f src.f --top-module coreTb

clean:
	rm -rf obj_dir $(LOG)
